//--- common/fc_pkg.sv
// Sizes assume 8-bit signed data; ACC_W must hold the longest dot product plus its bias
`default_nettype none

package fc_pkg;

  ////////////////////////////////////////
  // Widths and quantization
  ////////////////////////////////////////
  localparam int DATA_W      = 8;
  localparam int PROD_W      = 16;
  localparam int ACC_W       = 28;
  localparam int BIAS_W      = 16;
  localparam int MUL_STAGES  = 4;
  localparam int QUANT_SHIFT = 6;
  localparam int QUANT_MAX   = 127;
  localparam int IDX_W       = 8;

  ////////////////////////////////////////
  // Stream records
  ////////////////////////////////////////

  // One input element, shared feature with a weight and bias per neuron
  typedef struct packed {
    logic                     valid;
    logic signed [DATA_W-1:0] feat;
    logic signed [DATA_W-1:0] weight0;
    logic signed [DATA_W-1:0] weight1;
    logic signed [BIAS_W-1:0] bias0;
    logic signed [BIAS_W-1:0] bias1;
    logic                     first;
    logic                     last;
    logic                     layer_start;
  } fc_in_t;

  // Per-lane view of an input element
  typedef struct packed {
    logic                     valid;
    logic signed [DATA_W-1:0] feat;
    logic signed [DATA_W-1:0] weight;
    logic signed [BIAS_W-1:0] bias;
    logic                     first;
    logic                     last;
    logic                     layer_start;
  } lane_in_t;

  // Biased dot product of one finished vector
  typedef struct packed {
    logic                    valid;
    logic signed [ACC_W-1:0] sum;
    logic                    layer_start;
  } lane_result_t;

  // Requantized pair with the running layer argmax
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] q0;
    logic [DATA_W-1:0] q1;
    logic [IDX_W-1:0]  best_idx;
    logic [DATA_W-1:0] best_val;
  } fc_out_t;

endpackage

`default_nettype wire

//--- mac_lane/sm_multiplier.sv
// Adder tree depth is fixed for 8-bit operands; one new product accepted every cycle
`timescale 1ns/1ns
`default_nettype none

module sm_multiplier
  import fc_pkg::*;
(
  input  wire                      clk,
  input  wire                      rstn,
  input  wire                      in_valid,
  input  wire signed [DATA_W-1:0]  a,
  input  wire signed [DATA_W-1:0]  b,
  output logic                     out_valid,
  output logic signed [PROD_W-1:0] product
);

  localparam int NPP    = DATA_W;
  localparam int PAIR_W = DATA_W + 2;
  localparam int QUAD_W = DATA_W + 4;

  logic [DATA_W-1:0]     a_mag;
  logic [DATA_W-1:0]     b_mag;
  logic [MUL_STAGES-1:0] v_q;
  logic [MUL_STAGES-2:0] sign_q;

  logic [DATA_W-1:0]     pp_q   [NPP];
  logic [PAIR_W-1:0]     pair_d [NPP/2];
  logic [PAIR_W-1:0]     pair_q [NPP/2];
  logic [QUAD_W-1:0]     quad_d [NPP/4];
  logic [QUAD_W-1:0]     quad_q [NPP/4];
  logic [PROD_W-1:0]     mag_sum;

  // -128 maps to 8'h80, which still reads correctly as an unsigned magnitude
  assign a_mag = a[DATA_W-1] ? (~a + 1'b1) : a;
  assign b_mag = b[DATA_W-1] ? (~b + 1'b1) : b;

  ////////////////////////////////////////
  // Valid and sign pipeline
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      v_q <= '0;
    end else begin
      v_q <= {v_q[MUL_STAGES-2:0], in_valid};
    end
  end

  always_ff @(posedge clk) begin
    sign_q <= {sign_q[MUL_STAGES-3:0], a[DATA_W-1] ^ b[DATA_W-1]};
  end

  assign out_valid = v_q[MUL_STAGES-1];

  ////////////////////////////////////////
  // Stage 1, partial products
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < NPP; i++) begin
      pp_q[i] <= b_mag[i] ? a_mag : '0;
    end
  end

  // Stage 2 adds neighbours, the odd row weighted by two
  always_comb begin
    for (int j = 0; j < NPP/2; j++) begin
      pair_d[j] = PAIR_W'(pp_q[2*j]) + (PAIR_W'(pp_q[2*j+1]) << 1);
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < NPP/2; j++) begin
      pair_q[j] <= pair_d[j];
    end
  end

  // Stage 3 merges pairs into quads, upper pair weighted by four
  always_comb begin
    for (int k = 0; k < NPP/4; k++) begin
      quad_d[k] = QUAD_W'(pair_q[2*k]) + (QUAD_W'(pair_q[2*k+1]) << 2);
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < NPP/4; k++) begin
      quad_q[k] <= quad_d[k];
    end
  end

  ////////////////////////////////////////
  // Stage 4, final sum and sign
  ////////////////////////////////////////
  assign mag_sum = PROD_W'(quad_q[0]) + (PROD_W'(quad_q[1]) << (NPP/2));

  always_ff @(posedge clk) begin
    if (sign_q[MUL_STAGES-2]) begin
      product <= (~mag_sum) + 1'b1;
    end else begin
      product <= mag_sum;
    end
  end

endmodule

`default_nettype wire

//--- mac_lane/mac_lane.sv
// Sums wrap modulo 2^ACC_W; layer_start is taken from the vector's first element only
`timescale 1ns/1ns
`default_nettype none

module mac_lane
  import fc_pkg::*;
(
  input  wire               clk,
  input  wire               rstn,
  input  wire lane_in_t     lane_in,
  output lane_result_t      result
);

  typedef struct packed {
    logic first;
    logic last;
    logic layer_start;
  } side_t;

  side_t                    side_in;
  side_t                    side_q [MUL_STAGES];
  side_t                    side_out;
  logic signed [BIAS_W-1:0] bias_q [MUL_STAGES];
  logic                     prod_valid;
  logic signed [PROD_W-1:0] prod;
  logic signed [ACC_W-1:0]  acc;
  logic signed [ACC_W-1:0]  acc_next;
  logic                     layer_q;

  sm_multiplier u_mul (
    .clk       (clk),
    .rstn      (rstn),
    .in_valid  (lane_in.valid),
    .a         (lane_in.feat),
    .b         (lane_in.weight),
    .out_valid (prod_valid),
    .product   (prod)
  );

  // Flags are qualified by the strobe so bubbles carry no stray first or last
  assign side_in = '{first: lane_in.valid & lane_in.first,
                     last: lane_in.valid & lane_in.last,
                     layer_start: lane_in.valid & lane_in.first & lane_in.layer_start};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < MUL_STAGES; i++) begin
        side_q[i] <= '0;
      end
    end else begin
      side_q[0] <= side_in;
      for (int i = 1; i < MUL_STAGES; i++) begin
        side_q[i] <= side_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bias_q[0] <= lane_in.bias;
    for (int i = 1; i < MUL_STAGES; i++) begin
      bias_q[i] <= bias_q[i-1];
    end
  end

  assign side_out = side_q[MUL_STAGES-1];
  assign acc_next = (side_out.first ? '0 : acc) + ACC_W'(prod);

  ////////////////////////////////////////
  // Accumulate and bias add
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc          <= '0;
      layer_q      <= 1'b0;
      result.valid <= 1'b0;
    end else begin
      result.valid <= prod_valid & side_out.last;
      if (prod_valid) begin
        if (side_out.first) begin
          layer_q <= side_out.layer_start;
        end
        if (side_out.last) begin
          result.sum         <= acc_next + ACC_W'(bias_q[MUL_STAGES-1]);
          result.layer_start <= side_out.first ? side_out.layer_start : layer_q;
          acc                <= '0;
        end else begin
          acc <= acc_next;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/result_stage.sv
// Both lanes must run in lockstep; pair index wraps after 2^(IDX_W-1) pairs in one layer
`timescale 1ns/1ns
`default_nettype none

module result_stage
  import fc_pkg::*;
(
  input  wire                clk,
  input  wire                rstn,
  input  wire lane_result_t  lane0,
  input  wire lane_result_t  lane1,
  output fc_out_t            out
);

  // Smallest sum that saturates after the shift
  localparam int QUANT_LIM = (QUANT_MAX + 1) << QUANT_SHIFT;

  logic              v_s1;
  logic [DATA_W-1:0] q0_s1;
  logic [DATA_W-1:0] q1_s1;
  logic              ls_s1;

  logic [IDX_W-2:0]  pair_cnt;
  logic [IDX_W-2:0]  pair_base;
  logic [DATA_W-1:0] best_val;
  logic [IDX_W-1:0]  best_idx;
  logic              take0;
  logic              take1;
  logic [DATA_W-1:0] val0;
  logic [IDX_W-1:0]  idx0;
  logic [DATA_W-1:0] val_new;
  logic [IDX_W-1:0]  idx_new;

  // ReLU then shift with saturation at QUANT_MAX
  function automatic logic [DATA_W-1:0] requant(input logic signed [ACC_W-1:0] sum);
    if (sum < 0) begin
      return '0;
    end else if (sum >= QUANT_LIM) begin
      return DATA_W'(QUANT_MAX);
    end
    return DATA_W'(sum >>> QUANT_SHIFT);
  endfunction

  ////////////////////////////////////////
  // Stage 1 requantization
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (lane0.valid) begin
      q0_s1 <= requant(lane0.sum);
      q1_s1 <= requant(lane1.sum);
      ls_s1 <= lane0.layer_start;
    end
  end

  ////////////////////////////////////////
  // Stage 2 running argmax
  ////////////////////////////////////////
  assign pair_base = ls_s1 ? '0 : pair_cnt;

  // Strictly greater keeps the earliest candidate on a tie
  // Best 0 at index 0 after reset acts as none for the first pair
  assign take0 = ls_s1 | (q0_s1 > best_val);
  assign val0  = take0 ? q0_s1 : best_val;
  assign idx0  = take0 ? {pair_base, 1'b0} : best_idx;

  assign take1   = q1_s1 > val0;
  assign val_new = take1 ? q1_s1 : val0;
  assign idx_new = take1 ? {pair_base, 1'b1} : idx0;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      v_s1      <= 1'b0;
      pair_cnt  <= '0;
      best_val  <= '0;
      best_idx  <= '0;
      out.valid <= 1'b0;
    end else begin
      v_s1      <= lane0.valid;
      out.valid <= v_s1;
      if (v_s1) begin
        pair_cnt     <= pair_base + 1'b1;
        best_val     <= val_new;
        best_idx     <= idx_new;
        out.q0       <= q0_s1;
        out.q1       <= q1_s1;
        out.best_val <= val_new;
        out.best_idx <= idx_new;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/fc_neuron_pair.sv
// Two neurons share one feature stream; no back-pressure, output 7 cycles after a vector's last
`timescale 1ns/1ns
`default_nettype none

module fc_neuron_pair
  import fc_pkg::*;
(
  input  wire            clk,
  input  wire            rstn,
  input  wire fc_in_t    in,
  output fc_out_t        out
);

  lane_in_t     lane0_in;
  lane_in_t     lane1_in;
  lane_result_t lane0_res;
  lane_result_t lane1_res;

  // Feature and flags are broadcast, weight and bias are per neuron
  assign lane0_in = '{valid: in.valid, feat: in.feat, weight: in.weight0,
                      bias: in.bias0, first: in.first, last: in.last,
                      layer_start: in.layer_start};
  assign lane1_in = '{valid: in.valid, feat: in.feat, weight: in.weight1,
                      bias: in.bias1, first: in.first, last: in.last,
                      layer_start: in.layer_start};

  mac_lane u_lane0 (
    .clk     (clk),
    .rstn    (rstn),
    .lane_in (lane0_in),
    .result  (lane0_res)
  );

  mac_lane u_lane1 (
    .clk     (clk),
    .rstn    (rstn),
    .lane_in (lane1_in),
    .result  (lane1_res)
  );

  result_stage u_result_stage (
    .clk   (clk),
    .rstn  (rstn),
    .lane0 (lane0_res),
    .lane1 (lane1_res),
    .out   (out)
  );

endmodule

`default_nettype wire

//--- tb/fc_asserts.sv
// Bound into every result_stage; properties are ignored while rstn is low
`timescale 1ns/1ns
`default_nettype none

module fc_asserts
  import fc_pkg::*;
(
  input wire               clk,
  input wire               rstn,
  input wire lane_result_t lane0,
  input wire lane_result_t lane1,
  input wire fc_out_t      out
);

  // Requantized values stay inside the ReLU range
  a_out_range: assert property (@(posedge clk) disable iff (!rstn)
    out.valid |-> (out.q0 <= DATA_W'(QUANT_MAX)) && (out.q1 <= DATA_W'(QUANT_MAX)) &&
                  (out.best_val <= DATA_W'(QUANT_MAX)))
    else $error("output value above saturation limit");

  // Lanes finish their vectors in lockstep
  a_lockstep: assert property (@(posedge clk) disable iff (!rstn)
    lane0.valid == lane1.valid)
    else $error("lane result strobes out of step");

  // Running best covers the current pair
  a_best_covers: assert property (@(posedge clk) disable iff (!rstn)
    out.valid |-> (out.best_val >= out.q0) && (out.best_val >= out.q1))
    else $error("best value below current pair");

endmodule

bind result_stage fc_asserts u_fc_asserts (
  .clk   (clk),
  .rstn  (rstn),
  .lane0 (lane0),
  .lane1 (lane1),
  .out   (out)
);

`default_nettype wire

//--- tb/tb_fc_neuron_pair.sv
// Expects out.valid exactly 7 cycles after each last element; stops at the first mismatch
`timescale 1ns/1ns
`default_nettype none

module tb_fc_neuron_pair;
  import fc_pkg::*;

  typedef struct packed {
    logic [31:0] cyc;
    logic [7:0]  q0;
    logic [7:0]  q1;
    logic [7:0]  best_idx;
    logic [7:0]  best_val;
  } exp_t;

  logic    clk;
  logic    rstn;
  fc_in_t  stim;
  fc_out_t resp;

  int    cyc = 0;
  int    seed = 32'h78292c87;
  string cur_test = "reset";
  exp_t  exp_q[$];

  // Reference model state
  int m_acc0 = 0;
  int m_acc1 = 0;
  bit m_layer = 1'b0;
  int m_pairs = 0;
  bit m_none = 1'b1;
  int m_best_val = 0;
  int m_best_idx = 0;

  fc_neuron_pair u_fc_neuron_pair (
    .clk  (clk),
    .rstn (rstn),
    .in   (stim),
    .out  (resp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////
  task automatic check_val(input string what, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s %s: expected %0d, actual %0d", cur_test, what, exp_v, act_v);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Keeps the low ACC_W bits as a signed value
  function automatic int wrap_acc(input int v);
    logic signed [27:0] t;
    t = v[27:0];
    return int'(t);
  endfunction

  // ReLU then divide by 64, saturating from 2^13 upward
  function automatic int quantize(input int sum);
    if (sum < 0) begin
      return 0;
    end
    if (sum >= (1 << 13)) begin
      return 127;
    end
    return sum / 64;
  endfunction

  task automatic model_element(input logic signed [7:0] feat, w0, w1,
                               input logic signed [15:0] b0, b1,
                               input bit first, last, lstart);
    int   q0;
    int   q1;
    exp_t e;
    if (first) begin
      m_acc0  = wrap_acc(int'(feat) * int'(w0));
      m_acc1  = wrap_acc(int'(feat) * int'(w1));
      m_layer = lstart;
    end else begin
      m_acc0 = wrap_acc(m_acc0 + int'(feat) * int'(w0));
      m_acc1 = wrap_acc(m_acc1 + int'(feat) * int'(w1));
    end
    if (last) begin
      q0 = quantize(wrap_acc(m_acc0 + int'(b0)));
      q1 = quantize(wrap_acc(m_acc1 + int'(b1)));
      if (m_layer) begin
        m_pairs = 0;
        m_none  = 1'b1;
      end
      if (m_none || q0 > m_best_val) begin
        m_best_val = q0;
        m_best_idx = 2 * m_pairs;
      end
      m_none = 1'b0;
      if (q1 > m_best_val) begin
        m_best_val = q1;
        m_best_idx = 2 * m_pairs + 1;
      end
      m_pairs++;
      e.cyc      = 32'(cyc + 7);
      e.q0       = 8'(q0);
      e.q1       = 8'(q1);
      e.best_idx = 8'(m_best_idx);
      e.best_val = 8'(m_best_val);
      exp_q.push_back(e);
    end
  endtask

  // Sampled on the falling edge, away from the drive time
  always @(negedge clk) begin : monitor
    exp_t e;
    if (rstn && resp.valid) begin
      if (exp_q.size() == 0) begin
        $display("Output appeared in %s while no result was expected", cur_test);
        $display("Simulation failed");
        $fatal(1, "unexpected output");
      end else begin
        e = exp_q.pop_front();
        check_val("latency cycle", e.cyc, 32'(cyc));
        check_val("q0", 32'(e.q0), 32'(resp.q0));
        check_val("q1", 32'(e.q1), 32'(resp.q1));
        check_val("best_idx", 32'(e.best_idx), 32'(resp.best_idx));
        check_val("best_val", 32'(e.best_val), 32'(resp.best_val));
      end
    end
  end

  ////////////////////////////////////////
  // Driving
  ////////////////////////////////////////
  task automatic drive_elem(input logic signed [7:0] feat, w0, w1,
                            input logic signed [15:0] b0, b1,
                            input bit first, last, lstart);
    stim.valid       = 1'b1;
    stim.feat        = feat;
    stim.weight0     = w0;
    stim.weight1     = w1;
    stim.bias0       = b0;
    stim.bias1       = b1;
    stim.first       = first;
    stim.last        = last;
    stim.layer_start = lstart;
    model_element(feat, w0, w1, b0, b1, first, last, lstart);
    @(posedge clk);
    #1;
    stim.valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 50) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timed out in %s waiting for %0d outputs", cur_test, exp_q.size());
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  endtask

  // Feature 64 with zero bias makes each q equal its weight
  task automatic send_pair(input logic signed [7:0] w0, w1, input bit lstart);
    drive_elem(8'sd64, w0, w1, 16'sd0, 16'sd0, 1'b1, 1'b1, lstart);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_idle();
    cur_test = "reset_idle";
    repeat (10) begin
      @(negedge clk);
      check_val("out.valid", 32'd0, 32'(resp.valid));
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_single();
    cur_test = "single_element";
    drive_elem(8'sd50, 8'sd40, 8'sd30, 16'sd100, 16'sd50, 1'b1, 1'b1, 1'b1);
    idle_cycles(9);
    drive_elem(8'sd12, 8'sd9, 8'sd100, 16'sd200, 16'sd7, 1'b1, 1'b1, 1'b0);
    idle_cycles(9);
    drive_elem(8'sd3, 8'sd25, 8'sd2, 16'sd64, 16'sd0, 1'b1, 1'b1, 1'b0);
    wait_drain();
  endtask

  task automatic test_mixed();
    cur_test = "mixed_signs";
    drive_elem(8'sh80, 8'sh80, 8'sd3, 16'sd0, 16'sd0, 1'b1, 1'b0, 1'b1);
    drive_elem(8'sd100, 8'sd50, -8'sd90, 16'sd0, 16'sd0, 1'b0, 1'b0, 1'b0);
    drive_elem(-8'sd60, 8'sd20, 8'sd127, -16'sd300, 16'sd200, 1'b0, 1'b1, 1'b0);
    drive_elem(8'sd77, -8'sd3, 8'sd90, 16'sd0, 16'sd0, 1'b1, 1'b0, 1'b0);
    drive_elem(8'sd5, 8'sd120, 8'sd40, 16'sd10, -16'sd1000, 1'b0, 1'b1, 1'b0);
    drive_elem(-8'sd1, 8'sd127, 8'sh80, 16'sd500, -16'sd20, 1'b1, 1'b1, 1'b0);
    wait_drain();
  endtask

  task automatic test_argmax();
    cur_test = "argmax_layer";
    send_pair(8'sd10, 8'sd20, 1'b1);
    send_pair(8'sd30, 8'sd30, 1'b0);
    send_pair(8'sd15, 8'sd30, 1'b0);
    send_pair(8'sd45, 8'sd12, 1'b0);
    send_pair(8'sd45, 8'sd44, 1'b0);
    send_pair(8'sd5, 8'sd3, 1'b1);
    send_pair(8'sd3, 8'sd9, 1'b0);
    wait_drain();
  endtask

  task automatic test_random();
    int                 len;
    logic signed [7:0]  f;
    logic signed [7:0]  w0;
    logic signed [7:0]  w1;
    logic signed [15:0] b0;
    logic signed [15:0] b1;
    bit                 ls;
    cur_test = "random_stream";
    for (int v = 0; v < 20; v++) begin
      len = 1 + int'($unsigned($random(seed)) % 6);
      ls  = ($random(seed) & 3) == 0;
      for (int k = 0; k < len; k++) begin
        f  = 8'($random(seed));
        w0 = 8'($random(seed));
        w1 = 8'($random(seed));
        b0 = 16'($random(seed) % 4096);
        b1 = 16'($random(seed) % 4096);
        drive_elem(f, w0, w1, b0, b1, k == 0, k == len - 1, ls);
        idle_cycles($random(seed) & 3);
      end
    end
    wait_drain();
  endtask

  initial begin
    stim = '0;
    rstn = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
    test_idle();
    test_single();
    test_mixed();
    test_argmax();
    test_random();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
common/fc_pkg.sv
mac_lane/sm_multiplier.sv
mac_lane/mac_lane.sv
verilog/result_stage.sv
verilog/fc_neuron_pair.sv
tb/fc_asserts.sv
tb/tb_fc_neuron_pair.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status reports the result

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module tb_fc_neuron_pair \
  -o sim_fc_neuron_pair &&
./obj_dir/sim_fc_neuron_pair ||
{ echo "run_sim.sh: build or simulation returned an error"; exit 1; }
